// ==== yaw_trim_table.svh ====
`ifndef YAW_TRIM_TABLE_SVH
`define YAW_TRIM_TABLE_SVH

// Trims per throttle regime (low, mid, high) and yaw band, motors 1 to 4
localparam motor_trims_t yaw_trim_table [3][yaw_band_count] = '{
	'{ // Low regime, throttle 6 to 10
		'{8'sd0, -8'sd2, 8'sd15, 8'sd12},
		'{8'sd0, -8'sd1, 8'sd12, 8'sd8},
		'{8'sd0, 8'sd0, 8'sd8, 8'sd6},
		'{8'sd0, 8'sd0, 8'sd4, 8'sd2},
		'{8'sd0, 8'sd0, 8'sd0, 8'sd0},       // Yaw dead zone
		'{8'sd3, 8'sd2, 8'sd0, 8'sd0},
		'{8'sd6, 8'sd4, -8'sd1, 8'sd0},
		'{8'sd9, 8'sd8, -8'sd2, 8'sd1},
		'{8'sd13, 8'sd10, -8'sd3, 8'sd2},
		'{8'sd17, 8'sd14, -8'sd4, 8'sd3}
	},
	'{ // Mid regime, throttle 11 to 30
		'{-8'sd15, -8'sd15, 8'sd15, 8'sd10},
		'{-8'sd12, -8'sd12, 8'sd12, 8'sd8},
		'{-8'sd8, -8'sd8, 8'sd8, 8'sd5},
		'{-8'sd5, -8'sd5, 8'sd5, 8'sd2},
		'{8'sd0, 8'sd0, 8'sd0, 8'sd0},       // Yaw dead zone
		'{8'sd2, 8'sd2, -8'sd2, -8'sd2},
		'{8'sd4, 8'sd4, -8'sd4, -8'sd4},
		'{8'sd6, 8'sd6, -8'sd8, -8'sd8},
		'{8'sd8, 8'sd8, -8'sd12, -8'sd12},
		'{8'sd10, 8'sd10, -8'sd15, -8'sd15}
	},
	'{ // High regime, throttle above 30
		'{-8'sd20, -8'sd20, 8'sd0, 8'sd0},
		'{-8'sd15, -8'sd15, 8'sd0, 8'sd0},
		'{-8'sd10, -8'sd10, 8'sd0, 8'sd0},
		'{-8'sd5, -8'sd5, 8'sd0, 8'sd0},
		'{8'sd0, 8'sd0, 8'sd0, 8'sd0},       // Yaw dead zone
		'{8'sd0, 8'sd0, -8'sd4, -8'sd4},
		'{8'sd0, 8'sd0, -8'sd8, -8'sd8},
		'{8'sd0, 8'sd0, -8'sd12, -8'sd12},
		'{8'sd0, 8'sd0, -8'sd16, -8'sd16},
		'{8'sd0, 8'sd0, -8'sd20, -8'sd20}
	}
};

`endif

// ==== flight_pkg.sv ====
package flight_pkg;

	typedef logic [7:0] stick_t;          // Raw stick reading
	typedef logic [7:0] offset_t;         // Unsigned motor offset
	typedef logic signed [7:0] trim_t;    // Two's complement yaw trim
	typedef logic [3:0] motor_mask_t;     // Bit 0 is motor 1
	typedef logic [1:0] yaw_regime_t;     // 0 low, 1 mid, 2 high
	typedef logic [3:0] yaw_band_t;

	typedef struct packed {
		stick_t throttle;
		stick_t pitch;
		stick_t roll;
		stick_t yaw;
	} pilot_cmd_t;

	typedef struct packed {
		offset_t motor_1;
		offset_t motor_2;
		offset_t motor_3;
		offset_t motor_4;
	} motor_offsets_t;

	typedef struct packed {
		trim_t motor_1;
		trim_t motor_2;
		trim_t motor_3;
		trim_t motor_4;
	} motor_trims_t;

	localparam stick_t throttle_floor = 8'd2;       // Up to here the motors idle
	localparam stick_t throttle_ceiling = 8'd40;
	localparam offset_t throttle_base = 8'd8;

	localparam stick_t tilt_band_width = 8'd3;
	localparam stick_t tilt_low_limit = 8'd18;      // Top of the low side
	localparam stick_t tilt_high_start = 8'd23;     // 19 to 22 is the dead zone
	localparam stick_t tilt_ceiling = 8'd40;
	localparam offset_t tilt_max_mag = 8'd6;

	localparam stick_t yaw_regime_low_min = 8'd6;   // Below this the trims hold
	localparam stick_t yaw_regime_mid_min = 8'd11;
	localparam stick_t yaw_regime_high_min = 8'd31;

	localparam int yaw_band_count = 10;

	// Upper limits of bands 0 to 8, the last band takes everything above 38
	localparam stick_t yaw_band_limits [yaw_band_count-1] = '{
		8'd5, 8'd10, 8'd15, 8'd18, 8'd22, 8'd25, 8'd30, 8'd35, 8'd38
	};

endpackage

// ==== throttle_offset_gen.sv ====
module throttle_offset_gen #(
	parameter int unsigned throttle_extra = 15
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  flight_pkg::stick_t         throttle,
	output flight_pkg::motor_offsets_t offsets
);

	import flight_pkg::*;

	logic           in_band;
	offset_t        half_up;
	offset_t        level;
	motor_offsets_t offsets_d;

	// Active between 3 and 40 inclusive
	assign in_band = (throttle > throttle_floor) && (throttle <= throttle_ceiling);

	// Half the reading, rounded up
	assign half_up = offset_t'(throttle[7:1]) + offset_t'(throttle[0]);

	assign level = throttle_base + half_up + offset_t'(throttle_extra);

	always_comb
	begin
		offsets_d = '0;               // Idle or out of range
		if (in_band)
		begin
			offsets_d.motor_1 = level;
			offsets_d.motor_2 = level;
			offsets_d.motor_3 = level;
			offsets_d.motor_4 = level;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			offsets <= '0;
		end
		else
		begin
			offsets <= offsets_d;     // One cycle after the stick sample
		end
	end

endmodule

// ==== tilt_offset_gen.sv ====
module tilt_offset_gen #(
	parameter flight_pkg::motor_mask_t low_pair = 4'b0101,
	parameter flight_pkg::motor_mask_t high_pair = 4'b1010
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  flight_pkg::stick_t         tilt,
	output flight_pkg::motor_offsets_t offsets
);

	import flight_pkg::*;

	logic           low_side;
	logic           high_side;
	offset_t        low_step;
	offset_t        high_step;
	offset_t        mag;
	motor_mask_t    sel;
	motor_offsets_t offsets_d;

	assign low_side = (tilt <= tilt_low_limit);
	assign high_side = (tilt >= tilt_high_start) && (tilt <= tilt_ceiling);

	// Bottom band spans 0 to 3, so the steps count from a reading of 1
	assign low_step = (tilt == '0) ? '0 : offset_t'((tilt - 8'd1) / tilt_band_width);

	// Only meaningful on the high side
	assign high_step = offset_t'((tilt - tilt_high_start) / tilt_band_width);

	always_comb
	begin
		sel = '0;                     // Dead zone and out of range
		mag = '0;
		if (low_side)
		begin
			sel = low_pair;
			mag = tilt_max_mag - low_step;   // 6 falling to 1
		end
		else if (high_side)
		begin
			sel = high_pair;
			mag = high_step + 8'd1;          // 1 rising to 6
		end
	end

	assign offsets_d = '{
		motor_1: sel[0] ? mag : '0,
		motor_2: sel[1] ? mag : '0,
		motor_3: sel[2] ? mag : '0,
		motor_4: sel[3] ? mag : '0
	};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			offsets <= '0;
		end
		else
		begin
			offsets <= offsets_d;
		end
	end

endmodule

// ==== yaw_trim_gen.sv ====
module yaw_trim_gen (
	input  logic                     clk,
	input  logic                     arst_n,
	input  flight_pkg::stick_t       throttle,
	input  flight_pkg::stick_t       yaw,
	output flight_pkg::motor_trims_t trims
);

	import flight_pkg::*;

`include "yaw_trim_table.svh"

	logic         active;
	yaw_regime_t  regime;
	yaw_band_t    band;
	motor_trims_t trims_d;

	// At idle throttle the previous trims stay in place
	assign active = (throttle >= yaw_regime_low_min);

	always_comb
	begin
		if (throttle >= yaw_regime_high_min)
		begin
			regime = 2'd2;
		end
		else if (throttle >= yaw_regime_mid_min)
		begin
			regime = 2'd1;
		end
		else
		begin
			regime = 2'd0;            // Also covers idle, which never loads
		end
	end

	// Lowest band whose upper limit covers the reading
	always_comb
	begin
		band = yaw_band_t'(yaw_band_count - 1);
		for (int i = yaw_band_count - 2; i >= 0; i--)
		begin
			if (yaw <= yaw_band_limits[i])
			begin
				band = yaw_band_t'(i);
			end
		end
	end

	assign trims_d = yaw_trim_table[regime][band];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			trims <= '0;
		end
		else if (active)
		begin
			trims <= trims_d;
		end
	end

endmodule

// ==== motor_offset_top.sv ====
module motor_offset_top #(
	parameter int unsigned throttle_extra = 15
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  flight_pkg::pilot_cmd_t     cmd,
	output flight_pkg::motor_offsets_t throttle_out,
	output flight_pkg::motor_offsets_t pitch_out,
	output flight_pkg::motor_offsets_t roll_out,
	output flight_pkg::motor_trims_t   yaw_out
);

	import flight_pkg::*;

	localparam motor_mask_t pitch_low_pair = 4'b0101;   // Motors 1 and 3
	localparam motor_mask_t pitch_high_pair = 4'b1010;  // Motors 2 and 4
	localparam motor_mask_t roll_low_pair = 4'b0110;    // Motors 2 and 3
	localparam motor_mask_t roll_high_pair = 4'b1001;   // Motors 1 and 4

	throttle_offset_gen #(
		.throttle_extra (throttle_extra)
	) throttle_gen (
		.clk      (clk),
		.arst_n   (arst_n),
		.throttle (cmd.throttle),
		.offsets  (throttle_out)
	);

	tilt_offset_gen #(
		.low_pair  (pitch_low_pair),
		.high_pair (pitch_high_pair)
	) pitch_gen (
		.clk     (clk),
		.arst_n  (arst_n),
		.tilt    (cmd.pitch),
		.offsets (pitch_out)
	);

	tilt_offset_gen #(
		.low_pair  (roll_low_pair),
		.high_pair (roll_high_pair)
	) roll_gen (
		.clk     (clk),
		.arst_n  (arst_n),
		.tilt    (cmd.roll),
		.offsets (roll_out)
	);

	// Yaw also needs throttle to pick the regime
	yaw_trim_gen yaw_gen (
		.clk      (clk),
		.arst_n   (arst_n),
		.throttle (cmd.throttle),
		.yaw      (cmd.yaw),
		.trims    (yaw_out)
	);

endmodule

// ==== motor_offset_sva.sv ====
module motor_offset_sva (
	input logic                       clk,
	input logic                       arst_n,
	input flight_pkg::pilot_cmd_t     cmd,
	input flight_pkg::motor_offsets_t throttle_out,
	input flight_pkg::motor_offsets_t pitch_out,
	input flight_pkg::motor_offsets_t roll_out,
	input flight_pkg::motor_trims_t   yaw_out
);

	import flight_pkg::*;

	int fail_count;

	function automatic logic offset_ok(offset_t v);
		return (v == '0) || ((v >= 8'd25) && (v <= 8'd43));   // Idle or active throttle range
	endfunction

	// Pitch low pair is motors 1 and 3, high pair motors 2 and 4
	pitch_one_side: assert property (@(posedge clk) disable iff (!arst_n)
		!(((pitch_out.motor_1 | pitch_out.motor_3) != '0) &&
		  ((pitch_out.motor_2 | pitch_out.motor_4) != '0)))
		else
		begin
			$error("pitch drives both motor pairs");
			fail_count++;
		end

	// Roll low pair is motors 2 and 3, high pair motors 1 and 4
	roll_one_side: assert property (@(posedge clk) disable iff (!arst_n)
		!(((roll_out.motor_2 | roll_out.motor_3) != '0) &&
		  ((roll_out.motor_1 | roll_out.motor_4) != '0)))
		else
		begin
			$error("roll drives both motor pairs");
			fail_count++;
		end

	throttle_range: assert property (@(posedge clk) disable iff (!arst_n)
		offset_ok(throttle_out.motor_1) && offset_ok(throttle_out.motor_2) &&
		offset_ok(throttle_out.motor_3) && offset_ok(throttle_out.motor_4))
		else
		begin
			$error("throttle offset outside 0 or 25 to 43");
			fail_count++;
		end

	yaw_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(cmd.throttle <= 8'd5) |=> $stable(yaw_out))   // Idle throttle freezes the trims
		else
		begin
			$error("yaw trims changed at idle throttle");
			fail_count++;
		end

endmodule

bind motor_offset_top motor_offset_sva motor_offset_sva_inst (
	.clk          (clk),
	.arst_n       (arst_n),
	.cmd          (cmd),
	.throttle_out (throttle_out),
	.pitch_out    (pitch_out),
	.roll_out     (roll_out),
	.yaw_out      (yaw_out)
);

// ==== tb_motor_offset.sv ====
module tb_motor_offset;

	import flight_pkg::*;

	localparam int throttle_extra = 15;
	localparam int test_cycles = 8 + 64 + 48 + 4 + 48 + 8;   // Reset, sweeps, yaw tests
	localparam int timeout_cycles = 2 * test_cycles;

	logic           clk;
	logic           arst_n;
	pilot_cmd_t     cmd;
	motor_offsets_t throttle_out;
	motor_offsets_t pitch_out;
	motor_offsets_t roll_out;
	motor_trims_t   yaw_out;

	logic [31:0]    rng_state;
	int             cycle_count;
	int             check_count;
	int             error_count;
	int             test_errors;
	int             test_checks;
	motor_trims_t   yaw_expect;
	bit             yaw_known;     // Cleared when the trim table entry is not predicted

	motor_offset_top #(
		.throttle_extra (throttle_extra)
	) motor_offset_top_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd          (cmd),
		.throttle_out (throttle_out),
		.pitch_out    (pitch_out),
		.roll_out     (roll_out),
		.yaw_out      (yaw_out)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > timeout_cycles)
		begin
			$display("TIMEOUT: run exceeded %0d cycles", timeout_cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic motor_offsets_t throttle_expect(stick_t t);
		int v;
		v = 0;
		if ((t >= 3) && (t <= 40))
		begin
			v = 8 + (t + 1) / 2 + throttle_extra;   // Half rounded up
		end
		return '{offset_t'(v), offset_t'(v), offset_t'(v), offset_t'(v)};
	endfunction

	function automatic motor_offsets_t tilt_expect(stick_t r, motor_mask_t lo, motor_mask_t hi);
		int          mag;
		motor_mask_t sel;
		mag = 0;
		sel = '0;
		if (r <= 3)
		begin
			mag = 6;
			sel = lo;
		end
		else if (r <= 18)
		begin
			mag = 5 - (r - 4) / 3;
			sel = lo;
		end
		else if ((r >= 23) && (r <= 40))
		begin
			mag = (r - 20) / 3;
			sel = hi;
		end
		return '{sel[0] ? offset_t'(mag) : '0, sel[1] ? offset_t'(mag) : '0,
			sel[2] ? offset_t'(mag) : '0, sel[3] ? offset_t'(mag) : '0};
	endfunction

	// Throttle above 30, front pair for low yaw and rear pair for high yaw
	function automatic motor_trims_t high_yaw_expect(stick_t y);
		trim_t t;
		t = 8'sd0;
		if (y <= 5)       t = -8'sd20;
		else if (y <= 10) t = -8'sd15;
		else if (y <= 15) t = -8'sd10;
		else if (y <= 18) t = -8'sd5;
		else if (y <= 22) t = 8'sd0;
		else if (y <= 25) t = -8'sd4;
		else if (y <= 30) t = -8'sd8;
		else if (y <= 35) t = -8'sd12;
		else if (y <= 38) t = -8'sd16;
		else              t = -8'sd20;
		if (y <= 18)
			return '{t, t, 8'sd0, 8'sd0};
		return '{8'sd0, 8'sd0, t, t};
	endfunction

	task automatic compare_offsets(input string name, input motor_offsets_t got,
		input motor_offsets_t exp);
		check_count++;
		test_checks++;
		if (got !== exp)
		begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_trims(input string name, input motor_trims_t got,
		input motor_trims_t exp);
		check_count++;
		test_checks++;
		if (got !== exp)
		begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_response(input pilot_cmd_t c);
		// At throttle 5 or below the trims and their expected value both hold
		if (c.throttle > 30)
		begin
			yaw_expect = high_yaw_expect(c.yaw);
			yaw_known = 1'b1;
		end
		else if ((c.throttle >= 11) && (c.yaw >= 19) && (c.yaw <= 22))
		begin
			yaw_expect = '0;                   // Yaw dead zone
			yaw_known = 1'b1;
		end
		else if (c.throttle > 5)
		begin
			yaw_known = 1'b0;
		end
		compare_offsets("throttle_out", throttle_out, throttle_expect(c.throttle));
		compare_offsets("pitch_out", pitch_out, tilt_expect(c.pitch, 4'b0101, 4'b1010));
		compare_offsets("roll_out", roll_out, tilt_expect(c.roll, 4'b0110, 4'b1001));
		if (yaw_known)
			compare_trims("yaw_out", yaw_out, yaw_expect);
	endtask

	// Back to back commands, each result checked one cycle after its drive edge
	task automatic run_vectors(input pilot_cmd_t vecs[$]);
		pilot_cmd_t prev;
		bit         have_prev;
		have_prev = 1'b0;
		foreach (vecs[i])
		begin
			@(posedge clk);
			cmd <= vecs[i];
			@(negedge clk);
			if (have_prev)
				check_response(prev);
			prev = vecs[i];
			have_prev = 1'b1;
		end
		@(posedge clk);
		@(negedge clk);
		if (have_prev)
			check_response(prev);
	endtask

	task automatic finish_test(input string name);
		$display("test %s done, %0d checks, %0d errors", name, test_checks, test_errors);
		error_count += test_errors;
		test_errors = 0;
		test_checks = 0;
	endtask

	task automatic test_reset();
		repeat (5) @(posedge clk);
		@(negedge clk);
		compare_offsets("throttle_out", throttle_out, '0);   // Still in reset
		@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		compare_offsets("throttle_out", throttle_out, '0);
		compare_offsets("pitch_out", pitch_out, '0);
		compare_offsets("roll_out", roll_out, '0);
		compare_trims("yaw_out", yaw_out, '0);
		finish_test("reset");
	endtask

	task automatic test_throttle_sweep();
		pilot_cmd_t  vecs[$];
		logic [31:0] r;
		for (int t = 0; t <= 45; t++)
			vecs.push_back('{stick_t'(t), 8'd20, 8'd20, 8'd20});
		for (int i = 0; i < 16; i++)
		begin
			r = next_rand();
			vecs.push_back('{r[23:16], r[15:8], r[31:24], r[7:0]});
		end
		run_vectors(vecs);
		finish_test("throttle_sweep");
	endtask

	task automatic test_tilt_sweep();
		pilot_cmd_t vecs[$];
		for (int i = 0; i <= 45; i++)
			vecs.push_back('{8'd0, stick_t'(i), stick_t'(45 - i), 8'd20});
		run_vectors(vecs);
		finish_test("pitch_roll_sweep");
	endtask

	task automatic test_yaw_dead_zone();
		pilot_cmd_t vecs[$];
		vecs.push_back('{8'd35, 8'd20, 8'd20, 8'd0});        // Nonzero trims first
		vecs.push_back('{8'd20, 8'd20, 8'd20, 8'd20});
		run_vectors(vecs);
		finish_test("yaw_dead_zone");
	endtask

	task automatic test_yaw_high_throttle();
		pilot_cmd_t  vecs[$];
		logic [31:0] r;
		for (int y = 0; y <= 45; y++)
		begin
			r = next_rand();
			vecs.push_back('{stick_t'(31 + r[15:8] % 225), 8'd20, 8'd20, stick_t'(y)});
		end
		run_vectors(vecs);
		finish_test("yaw_high_throttle");
	endtask

	task automatic test_yaw_hold();
		pilot_cmd_t vecs[$];
		vecs.push_back('{8'd35, 8'd20, 8'd20, 8'd12});
		vecs.push_back('{8'd3, 8'd20, 8'd20, 8'd40});
		vecs.push_back('{8'd0, 8'd20, 8'd20, 8'd2});
		vecs.push_back('{8'd5, 8'd20, 8'd20, 8'd30});
		vecs.push_back('{8'd35, 8'd20, 8'd20, 8'd44});
		vecs.push_back('{8'd3, 8'd20, 8'd20, 8'd0});
		run_vectors(vecs);
		finish_test("yaw_hold");
	endtask

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b0;
		cmd = '0;
		rng_state = 32'hf202_7679;
		cycle_count = 0;
		check_count = 0;
		error_count = 0;
		test_errors = 0;
		test_checks = 0;
		yaw_expect = '0;
		yaw_known = 1'b1;
		test_reset();
		test_throttle_sweep();
		test_tilt_sweep();
		test_yaw_dead_zone();
		test_yaw_high_throttle();
		test_yaw_hold();
		error_count += motor_offset_top_inst.motor_offset_sva_inst.fail_count;   // Bound checks
		$display("summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+.
flight_pkg.sv
throttle_offset_gen.sv
tilt_offset_gen.sv
yaw_trim_gen.sv
motor_offset_top.sv
motor_offset_sva.sv
tb_motor_offset.sv
